//--- logic/gps_pkg.sv
package gps_pkg;

   // Sample and configuration widths.
   localparam int SAMPLE_WIDTH  = 3;
   localparam int CARRIER_WIDTH = 3;
   localparam int PRN_WIDTH     = 5;
   localparam int PHASE_WIDTH   = 16;

   // C/A code structure.
   localparam int CODE_LENGTH      = 1023;
   localparam int SAMPLES_PER_CHIP = 4;
   localparam int GOLD_STAGES      = 10;
   localparam int CHIP_COUNT_WIDTH = 2;
   localparam int REPLICA_SPACING  = 2;

   localparam logic [CHIP_COUNT_WIDTH-1:0] CHIP_COUNT_LAST =
      CHIP_COUNT_WIDTH'(SAMPLES_PER_CHIP - 1);

   // One epoch is a full code period.
   localparam int ACC_SAMPLES        = CODE_LENGTH * SAMPLES_PER_CHIP;
   localparam int SAMPLE_COUNT_WIDTH = 12;

   localparam logic [SAMPLE_COUNT_WIDTH-1:0] SAMPLE_COUNT_LAST =
      SAMPLE_COUNT_WIDTH'(ACC_SAMPLES - 1);

   // Accumulation and power widths.
   localparam int ACC_WIDTH     = 17;
   localparam int MAG_WIDTH     = 16;
   localparam int POWER_WIDTH   = 33;
   localparam int POWER_LATENCY = 6;

   typedef enum logic {
      MODE_IDLE,
      MODE_RUN
   } chan_mode_t;

   // G2 phase-select stages per PRN, packed as {first, second} in hex nibbles.
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2a, 8'h18, 8'h29,
      8'h3a, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9a,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8a, 8'h16, 8'h27, 8'h38, 8'h49
   };

   // Eight-step carrier, indexed by the top phase bits.
   localparam logic signed [CARRIER_WIDTH-1:0] CARRIER_COS [8] = '{
      3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1, 3'sd0, 3'sd1
   };

   // Quarter cycle behind the cosine.
   localparam logic signed [CARRIER_WIDTH-1:0] CARRIER_SIN [8] = '{
      3'sd0, 3'sd1, 3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1
   };

endpackage

//--- logic/channel_ctrl.sv
`timescale 1ns/1ps

module channel_ctrl (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  gps_pkg::chan_mode_t               i_mode,
   input  logic                              i_cfg_load,
   input  logic [gps_pkg::PRN_WIDTH-1:0]     i_prn,
   input  logic [gps_pkg::PHASE_WIDTH-1:0]   i_doppler_inc,
   input  logic                              i_data_valid,
   output logic [gps_pkg::PRN_WIDTH-1:0]     o_prn,
   output logic [gps_pkg::PHASE_WIDTH-1:0]   o_doppler_inc,
   output logic                              o_run_start,
   output logic                              o_sample_en,
   output logic                              o_dump
);

   gps_pkg::chan_mode_t                        mode_q;
   logic [gps_pkg::SAMPLE_COUNT_WIDTH-1:0]     sample_cnt;

   // Configuration registers.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_prn         <= '0;
         o_doppler_inc <= '0;
      end else if (i_cfg_load) begin
         o_prn         <= i_prn;
         o_doppler_inc <= i_doppler_inc;
      end
   end

   // Remember the last mode to spot the switch into run.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mode_q      <= gps_pkg::MODE_IDLE;
         o_run_start <= 1'b0;
      end else begin
         mode_q      <= i_mode;
         o_run_start <= (i_mode == gps_pkg::MODE_RUN) && (mode_q == gps_pkg::MODE_IDLE);
      end
   end

   // Samples count from the cycle after run start onwards.
   assign o_sample_en = i_data_valid && (i_mode == gps_pkg::MODE_RUN) &&
                        (mode_q == gps_pkg::MODE_RUN) && !o_run_start;

   // Epoch counter and dump strobe.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sample_cnt <= '0;
         o_dump     <= 1'b0;
      end else if (o_run_start) begin
         sample_cnt <= '0;
         o_dump     <= 1'b0;
      end else if (o_sample_en && (sample_cnt == gps_pkg::SAMPLE_COUNT_LAST)) begin
         sample_cnt <= '0;
         o_dump     <= 1'b1;
      end else begin
         sample_cnt <= o_sample_en ? sample_cnt + 1'b1 : sample_cnt;
         o_dump     <= 1'b0;
      end
   end

endmodule

//--- logic/ca_code_gen.sv
`timescale 1ns/1ps

module ca_code_gen (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic                          i_run_start,
   input  logic                          i_sample_en,
   input  logic                          i_dump,
   input  logic [gps_pkg::PRN_WIDTH-1:0] i_prn,
   output logic                          o_chip_early,
   output logic                          o_chip_prompt,
   output logic                          o_chip_late
);

   logic [gps_pkg::GOLD_STAGES:1]          g1;
   logic [gps_pkg::GOLD_STAGES:1]          g2;
   logic [gps_pkg::CHIP_COUNT_WIDTH-1:0]   chip_cnt;
   logic [2*gps_pkg::REPLICA_SPACING-1:0]  chip_dly;
   logic [7:0]                             taps;
   logic [3:0]                             tap_a;
   logic [3:0]                             tap_b;
   logic                                   g1_fb;
   logic                                   g2_fb;
   logic                                   chip_end;

   assign taps  = gps_pkg::G2_TAPS[i_prn];
   assign tap_a = taps[7:4];
   assign tap_b = taps[3:0];

   assign g1_fb = g1[3] ^ g1[10];
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

   // Last sample of the current chip.
   assign chip_end = i_sample_en && (chip_cnt == gps_pkg::CHIP_COUNT_LAST);

   // Samples within a chip.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         chip_cnt <= '0;
      end else if (i_run_start) begin
         chip_cnt <= '0;
      end else if (i_sample_en) begin
         chip_cnt <= chip_cnt + 1'b1;
      end
   end

   // Gold registers restart at every epoch boundary.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         g1 <= '1;
         g2 <= '1;
      end else if (i_run_start || i_dump) begin
         g1 <= '1;
         g2 <= '1;
      end else if (chip_end) begin
         g1 <= {g1[9:1], g1_fb};
         g2 <= {g2[9:1], g2_fb};
      end
   end

   assign o_chip_early = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Half-chip replica delay line.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         chip_dly <= '0;
      end else if (i_run_start) begin
         chip_dly <= '0;
      end else if (i_sample_en) begin
         chip_dly <= {chip_dly[2*gps_pkg::REPLICA_SPACING-2:0], o_chip_early};
      end
   end

   assign o_chip_prompt = chip_dly[gps_pkg::REPLICA_SPACING-1];
   assign o_chip_late   = chip_dly[2*gps_pkg::REPLICA_SPACING-1];

endmodule

//--- logic/carrier_nco.sv
`timescale 1ns/1ps

module carrier_nco (
   input  logic                                     clk,
   input  logic                                     i_rst_n,
   input  logic                                     i_run_start,
   input  logic                                     i_sample_en,
   input  logic [gps_pkg::PHASE_WIDTH-1:0]          i_doppler_inc,
   output logic signed [gps_pkg::CARRIER_WIDTH-1:0] o_carrier_i,
   output logic signed [gps_pkg::CARRIER_WIDTH-1:0] o_carrier_q
);

   logic [gps_pkg::PHASE_WIDTH-1:0] phase;
   logic [2:0]                      phase_idx;

   // Phase accumulator wraps naturally.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= '0;
      end else if (i_run_start) begin
         phase <= '0;
      end else if (i_sample_en) begin
         phase <= phase + i_doppler_inc;
      end
   end

   // Top three bits pick one of eight carrier steps.
   assign phase_idx = phase[gps_pkg::PHASE_WIDTH-1 -: 3];

   assign o_carrier_i = gps_pkg::CARRIER_COS[phase_idx];
   assign o_carrier_q = gps_pkg::CARRIER_SIN[phase_idx];

endmodule

//--- logic/correlator.sv
`timescale 1ns/1ps

module correlator (
   input  logic                                     clk,
   input  logic                                     i_rst_n,
   input  logic                                     i_run_start,
   input  logic                                     i_sample_en,
   input  logic                                     i_dump,
   input  logic signed [gps_pkg::SAMPLE_WIDTH-1:0]  i_data,
   input  logic signed [gps_pkg::CARRIER_WIDTH-1:0] i_carrier_i,
   input  logic signed [gps_pkg::CARRIER_WIDTH-1:0] i_carrier_q,
   input  logic                                     i_chip,
   output logic signed [gps_pkg::ACC_WIDTH-1:0]     o_acc_i,
   output logic signed [gps_pkg::ACC_WIDTH-1:0]     o_acc_q
);

   localparam int PROD_WIDTH = gps_pkg::SAMPLE_WIDTH + gps_pkg::CARRIER_WIDTH;

   logic signed [PROD_WIDTH-1:0]         prod_i;
   logic signed [PROD_WIDTH-1:0]         prod_q;
   logic signed [gps_pkg::ACC_WIDTH-1:0] wipe_i;
   logic signed [gps_pkg::ACC_WIDTH-1:0] wipe_q;

   // Carrier wipe-off.
   assign prod_i = i_data * i_carrier_i;
   assign prod_q = i_data * i_carrier_q;

   // Chip value 1 stands for -1.
   assign wipe_i = i_chip ? -prod_i : prod_i;
   assign wipe_q = i_chip ? -prod_q : prod_q;

   // The final sums are visible during dump, then the next epoch begins.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_acc_i <= '0;
         o_acc_q <= '0;
      end else if (i_run_start) begin
         o_acc_i <= '0;
         o_acc_q <= '0;
      end else if (i_dump) begin
         o_acc_i <= i_sample_en ? wipe_i : '0;
         o_acc_q <= i_sample_en ? wipe_q : '0;
      end else if (i_sample_en) begin
         o_acc_i <= o_acc_i + wipe_i;
         o_acc_q <= o_acc_q + wipe_q;
      end
   end

endmodule

//--- logic/power_pipeline.sv
`timescale 1ns/1ps

module power_pipeline (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_dump,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_i_early,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_q_early,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_i_prompt,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_q_prompt,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_i_late,
   input  logic signed [gps_pkg::ACC_WIDTH-1:0] i_acc_q_late,
   output logic                                 o_i2q2_valid,
   output logic [gps_pkg::POWER_WIDTH-1:0]      o_i2q2_early,
   output logic [gps_pkg::POWER_WIDTH-1:0]      o_i2q2_prompt,
   output logic [gps_pkg::POWER_WIDTH-1:0]      o_i2q2_late
);

   typedef enum logic [1:0] {
      SEL_EARLY,
      SEL_PROMPT,
      SEL_LATE,
      SEL_IDLE
   } power_sel_t;

   logic [gps_pkg::MAG_WIDTH-1:0]   mag_i_early, mag_q_early;
   logic [gps_pkg::MAG_WIDTH-1:0]   mag_i_prompt, mag_q_prompt;
   logic [gps_pkg::MAG_WIDTH-1:0]   mag_i_late, mag_q_late;
   logic [gps_pkg::MAG_WIDTH-1:0]   sq_in_i, sq_in_q;
   logic [2*gps_pkg::MAG_WIDTH-1:0] i2, q2;
   logic [gps_pkg::POWER_WIDTH-1:0] sum;
   power_sel_t                      sel, sel_d1, sel_d2;

   function automatic logic [gps_pkg::MAG_WIDTH-1:0] magnitude(
      input logic signed [gps_pkg::ACC_WIDTH-1:0] value
   );
      logic signed [gps_pkg::ACC_WIDTH-1:0] pos;
      pos = value[gps_pkg::ACC_WIDTH-1] ? -value : value;
      return pos[gps_pkg::MAG_WIDTH-1:0];
   endfunction

   // Magnitudes are captured while the correlators hold their sums.
   always_ff @(posedge clk) begin
      if (i_dump) begin
         mag_i_early  <= magnitude(i_acc_i_early);
         mag_q_early  <= magnitude(i_acc_q_early);
         mag_i_prompt <= magnitude(i_acc_i_prompt);
         mag_q_prompt <= magnitude(i_acc_q_prompt);
         mag_i_late   <= magnitude(i_acc_i_late);
         mag_q_late   <= magnitude(i_acc_q_late);
      end
   end

   // Select walks early, prompt, late; the two delays follow it down the pipe.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sel    <= SEL_IDLE;
         sel_d1 <= SEL_IDLE;
         sel_d2 <= SEL_IDLE;
      end else begin
         if (i_dump) begin
            sel <= SEL_EARLY;
         end else if (sel != SEL_IDLE) begin
            sel <= power_sel_t'(sel + 2'd1);
         end
         sel_d1 <= sel;
         sel_d2 <= sel_d1;
      end
   end

   always_comb begin
      case (sel)
         SEL_PROMPT: begin
            sq_in_i = mag_i_prompt;
            sq_in_q = mag_q_prompt;
         end
         SEL_LATE: begin
            sq_in_i = mag_i_late;
            sq_in_q = mag_q_late;
         end
         default: begin
            sq_in_i = mag_i_early;
            sq_in_q = mag_q_early;
         end
      endcase
   end

   // Squarer pair and adder stage.
   always_ff @(posedge clk) begin
      i2  <= sq_in_i * sq_in_i;
      q2  <= sq_in_q * sq_in_q;
      sum <= i2 + q2;
   end

   // Steer each sum into its own result register.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_i2q2_early  <= '0;
         o_i2q2_prompt <= '0;
         o_i2q2_late   <= '0;
         o_i2q2_valid  <= 1'b0;
      end else begin
         if (sel_d2 == SEL_EARLY) begin
            o_i2q2_early <= sum;
         end
         if (sel_d2 == SEL_PROMPT) begin
            o_i2q2_prompt <= sum;
         end
         if (sel_d2 == SEL_LATE) begin
            o_i2q2_late <= sum;
         end
         o_i2q2_valid <= (sel_d2 == SEL_LATE);
      end
   end

endmodule

//--- logic/gps_channel.sv
`timescale 1ns/1ps

module gps_channel (
   input  logic                                    clk,
   input  logic                                    i_rst_n,
   input  gps_pkg::chan_mode_t                     i_mode,
   input  logic                                    i_cfg_load,
   input  logic [gps_pkg::PRN_WIDTH-1:0]           i_prn,
   input  logic [gps_pkg::PHASE_WIDTH-1:0]         i_doppler_inc,
   input  logic                                    i_data_valid,
   input  logic signed [gps_pkg::SAMPLE_WIDTH-1:0] i_data,
   output logic                                    o_dump,
   output logic signed [gps_pkg::ACC_WIDTH-1:0]    o_acc_i_prompt,
   output logic signed [gps_pkg::ACC_WIDTH-1:0]    o_acc_q_prompt,
   output logic                                    o_i2q2_valid,
   output logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_early,
   output logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_prompt,
   output logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_late
);

   logic [gps_pkg::PRN_WIDTH-1:0]            prn;
   logic [gps_pkg::PHASE_WIDTH-1:0]          doppler_inc;
   logic                                     run_start;
   logic                                     sample_en;
   logic                                     dump;
   logic                                     chip_early, chip_prompt, chip_late;
   logic signed [gps_pkg::CARRIER_WIDTH-1:0] carrier_i, carrier_q;
   logic signed [gps_pkg::ACC_WIDTH-1:0]     acc_i_early, acc_q_early;
   logic signed [gps_pkg::ACC_WIDTH-1:0]     acc_i_late, acc_q_late;

   channel_ctrl u_ctrl (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_mode        (i_mode),
      .i_cfg_load    (i_cfg_load),
      .i_prn         (i_prn),
      .i_doppler_inc (i_doppler_inc),
      .i_data_valid  (i_data_valid),
      .o_prn         (prn),
      .o_doppler_inc (doppler_inc),
      .o_run_start   (run_start),
      .o_sample_en   (sample_en),
      .o_dump        (dump)
   );

   ca_code_gen u_code (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_run_start   (run_start),
      .i_sample_en   (sample_en),
      .i_dump        (dump),
      .i_prn         (prn),
      .o_chip_early  (chip_early),
      .o_chip_prompt (chip_prompt),
      .o_chip_late   (chip_late)
   );

   carrier_nco u_nco (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_run_start   (run_start),
      .i_sample_en   (sample_en),
      .i_doppler_inc (doppler_inc),
      .o_carrier_i   (carrier_i),
      .o_carrier_q   (carrier_q)
   );

   // Three subchannels share the carrier and differ only in code phase.
   correlator u_early (
      .clk(clk), .i_rst_n(i_rst_n), .i_run_start(run_start),
      .i_sample_en(sample_en), .i_dump(dump), .i_data(i_data),
      .i_carrier_i(carrier_i), .i_carrier_q(carrier_q), .i_chip(chip_early),
      .o_acc_i(acc_i_early), .o_acc_q(acc_q_early)
   );

   correlator u_prompt (
      .clk(clk), .i_rst_n(i_rst_n), .i_run_start(run_start),
      .i_sample_en(sample_en), .i_dump(dump), .i_data(i_data),
      .i_carrier_i(carrier_i), .i_carrier_q(carrier_q), .i_chip(chip_prompt),
      .o_acc_i(o_acc_i_prompt), .o_acc_q(o_acc_q_prompt)
   );

   correlator u_late (
      .clk(clk), .i_rst_n(i_rst_n), .i_run_start(run_start),
      .i_sample_en(sample_en), .i_dump(dump), .i_data(i_data),
      .i_carrier_i(carrier_i), .i_carrier_q(carrier_q), .i_chip(chip_late),
      .o_acc_i(acc_i_late), .o_acc_q(acc_q_late)
   );

   power_pipeline u_power (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_dump         (dump),
      .i_acc_i_early  (acc_i_early),
      .i_acc_q_early  (acc_q_early),
      .i_acc_i_prompt (o_acc_i_prompt),
      .i_acc_q_prompt (o_acc_q_prompt),
      .i_acc_i_late   (acc_i_late),
      .i_acc_q_late   (acc_q_late),
      .o_i2q2_valid   (o_i2q2_valid),
      .o_i2q2_early   (o_i2q2_early),
      .o_i2q2_prompt  (o_i2q2_prompt),
      .o_i2q2_late    (o_i2q2_late)
   );

   assign o_dump = dump;

endmodule

//--- sim/gps_channel_assert.sv
`timescale 1ns/1ps

module gps_channel_assert (
   input logic                clk,
   input logic                i_rst_n,
   input gps_pkg::chan_mode_t i_mode,
   input logic                i_dump,
   input logic                i_i2q2_valid
);

   // Power results flagged for one cycle only.
   valid_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_i2q2_valid |=> !i_i2q2_valid)
      else $error("o_i2q2_valid stayed high for more than one cycle");

   dump_to_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dump |-> ##(gps_pkg::POWER_LATENCY) i_i2q2_valid)
      else $error("o_i2q2_valid did not follow o_dump after the power latency");

   // A dump always follows a sample taken in run mode.
   dump_in_run: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dump |-> $past(i_mode) == gps_pkg::MODE_RUN)
      else $error("o_dump occurred while the channel was idle");

endmodule

bind gps_channel gps_channel_assert u_assert (
   .clk          (clk),
   .i_rst_n      (i_rst_n),
   .i_mode       (i_mode),
   .i_dump       (o_dump),
   .i_i2q2_valid (o_i2q2_valid)
);

//--- sim/gps_channel_tb.sv
`timescale 1ns/1ps

module gps_channel_tb;

   localparam int CLK_PERIOD     = 100;
   localparam int RUNS           = 2;
   localparam int EPOCHS         = 3;
   localparam int TIMEOUT_CYCLES = RUNS * EPOCHS * gps_pkg::ACC_SAMPLES * 2 + 2000;

   logic                                    clk;
   logic                                    i_rst_n;
   gps_pkg::chan_mode_t                     i_mode;
   logic                                    i_cfg_load;
   logic [gps_pkg::PRN_WIDTH-1:0]           i_prn;
   logic [gps_pkg::PHASE_WIDTH-1:0]         i_doppler_inc;
   logic                                    i_data_valid;
   logic signed [gps_pkg::SAMPLE_WIDTH-1:0] i_data;
   logic                                    o_dump;
   logic signed [gps_pkg::ACC_WIDTH-1:0]    o_acc_i_prompt;
   logic signed [gps_pkg::ACC_WIDTH-1:0]    o_acc_q_prompt;
   logic                                    o_i2q2_valid;
   logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_early;
   logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_prompt;
   logic [gps_pkg::POWER_WIDTH-1:0]         o_i2q2_late;

   logic [31:0]                     lfsr_state;
   int                              errors;
   int                              checks;

   // Reference model state.
   bit                              code [gps_pkg::CODE_LENGTH];
   logic [gps_pkg::PRN_WIDTH-1:0]   cfg_prn;
   logic [gps_pkg::PHASE_WIDTH-1:0] cfg_inc;
   logic [gps_pkg::PHASE_WIDTH-1:0] model_inc;
   logic [gps_pkg::PHASE_WIDTH-1:0] model_phase;
   bit                              running;
   bit                              dump_exp;
   int                              model_n;
   int                              model_cnt;
   int                              dumps_seen;
   int                              valid_wait;
   longint                          acc_i [3];
   longint                          acc_q [3];
   longint                          pow_exp [3];

   gps_channel dut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken.
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < n; k++) begin
         value      = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return value;
   endfunction

   function automatic logic random_valid();
      return random_bits(2) != 0;
   endfunction

   task automatic check_value(input string what, input logic signed [63:0] got,
                              input logic signed [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // Full C/A period from the two Gold registers.
   task automatic build_code(input logic [gps_pkg::PRN_WIDTH-1:0] prn);
      bit g1 [1:10];
      bit g2 [1:10];
      bit fb1;
      bit fb2;
      int tap_a;
      int tap_b;
      tap_a = gps_pkg::G2_TAPS[prn][7:4];
      tap_b = gps_pkg::G2_TAPS[prn][3:0];
      for (int k = 1; k <= 10; k++) begin
         g1[k] = 1'b1;
         g2[k] = 1'b1;
      end
      for (int c = 0; c < gps_pkg::CODE_LENGTH; c++) begin
         code[c] = g1[10] ^ g2[tap_a] ^ g2[tap_b];
         fb1 = g1[3] ^ g1[10];
         fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         for (int k = 10; k > 1; k--) begin
            g1[k] = g1[k-1];
            g2[k] = g2[k-1];
         end
         g1[1] = fb1;
         g2[1] = fb2;
      end
   endtask

   // Delay line starts cleared, so chips before run start read as zero.
   function automatic bit chip_at(input int n);
      if (n < 0) begin
         return 1'b0;
      end
      return code[(n / gps_pkg::SAMPLES_PER_CHIP) % gps_pkg::CODE_LENGTH];
   endfunction

   task automatic model_sample(input int data);
      int ci;
      int cq;
      int sign;
      ci = gps_pkg::CARRIER_COS[model_phase[gps_pkg::PHASE_WIDTH-1 -: 3]];
      cq = gps_pkg::CARRIER_SIN[model_phase[gps_pkg::PHASE_WIDTH-1 -: 3]];
      // Early, prompt and late sit half a chip apart.
      for (int s = 0; s < 3; s++) begin
         sign = chip_at(model_n - 2 * s) ? -1 : 1;
         acc_i[s] += data * ci * sign;
         acc_q[s] += data * cq * sign;
      end
      model_phase = model_phase + model_inc;
      model_n++;
      model_cnt++;
      if (model_cnt == gps_pkg::ACC_SAMPLES) begin
         model_cnt = 0;
         dump_exp  = 1'b1;
      end
   endtask

   task automatic check_outputs();
      bit dump_now;
      bit valid_now;
      dump_now  = dump_exp;
      dump_exp  = 1'b0;
      valid_now = 1'b0;
      if (valid_wait > 0) begin
         valid_wait--;
         valid_now = (valid_wait == 0);
      end
      check_value("o_dump", o_dump, dump_now);
      check_value("o_i2q2_valid", o_i2q2_valid, valid_now);
      if (dump_now) begin
         check_value("o_acc_i_prompt", o_acc_i_prompt, acc_i[1]);
         check_value("o_acc_q_prompt", o_acc_q_prompt, acc_q[1]);
         for (int s = 0; s < 3; s++) begin
            pow_exp[s] = acc_i[s] * acc_i[s] + acc_q[s] * acc_q[s];
            acc_i[s]   = 0;
            acc_q[s]   = 0;
         end
         valid_wait = gps_pkg::POWER_LATENCY;
         dumps_seen++;
      end
      if (valid_now) begin
         check_value("o_i2q2_early", o_i2q2_early, pow_exp[0]);
         check_value("o_i2q2_prompt", o_i2q2_prompt, pow_exp[1]);
         check_value("o_i2q2_late", o_i2q2_late, pow_exp[2]);
      end
   endtask

   // One clock of stimulus, then check and advance the model.
   task automatic drive_cycle(input gps_pkg::chan_mode_t mode, input logic valid,
                              input logic cfg);
      logic signed [gps_pkg::SAMPLE_WIDTH-1:0] data;
      logic [gps_pkg::PRN_WIDTH-1:0]           prn;
      logic [gps_pkg::PHASE_WIDTH-1:0]         inc;
      data = random_bits(gps_pkg::SAMPLE_WIDTH);
      prn  = random_bits(gps_pkg::PRN_WIDTH);
      inc  = random_bits(gps_pkg::PHASE_WIDTH);
      @(posedge clk);
      i_mode        <= mode;
      i_data_valid  <= valid;
      i_data        <= data;
      i_cfg_load    <= cfg;
      i_prn         <= prn;
      i_doppler_inc <= inc;
      @(negedge clk);
      check_outputs();
      if (cfg) begin
         cfg_prn = prn;
         cfg_inc = inc;
      end
      if (mode == gps_pkg::MODE_RUN && !running) begin
         running     = 1'b1;
         build_code(cfg_prn);
         model_inc   = cfg_inc;
         model_phase = '0;
         model_n     = 0;
         model_cnt   = 0;
         for (int s = 0; s < 3; s++) begin
            acc_i[s] = 0;
            acc_q[s] = 0;
         end
      end else if (mode == gps_pkg::MODE_IDLE) begin
         running = 1'b0;
      end
      if (running && valid) begin
         model_sample(data);
      end
   endtask

   task automatic do_run();
      int target;
      repeat (8) drive_cycle(gps_pkg::MODE_IDLE, random_valid(), 1'b0);
      drive_cycle(gps_pkg::MODE_IDLE, random_valid(), 1'b1);
      repeat (4) drive_cycle(gps_pkg::MODE_IDLE, random_valid(), 1'b0);
      // No samples while the run start settles.
      repeat (2) drive_cycle(gps_pkg::MODE_RUN, 1'b0, 1'b0);
      target = dumps_seen + EPOCHS;
      while (dumps_seen < target) begin
         drive_cycle(gps_pkg::MODE_RUN, random_valid(), 1'b0);
      end
      // Partial epoch stops a few samples short of a dump.
      while (model_cnt < gps_pkg::ACC_SAMPLES - 4) begin
         drive_cycle(gps_pkg::MODE_RUN, random_valid(), 1'b0);
      end
      // Samples offered while idle must not complete the epoch.
      repeat (16) drive_cycle(gps_pkg::MODE_IDLE, random_valid(), 1'b0);
   endtask

   initial begin
      i_rst_n       = 1'b0;
      i_mode        = gps_pkg::MODE_IDLE;
      i_cfg_load    = 1'b0;
      i_prn         = '0;
      i_doppler_inc = '0;
      i_data_valid  = 1'b0;
      i_data        = '0;
      lfsr_state    = 32'h0cc1d92b;
      errors        = 0;
      checks        = 0;
      cfg_prn       = '0;
      cfg_inc       = '0;
      running       = 1'b0;
      dump_exp      = 1'b0;
      dumps_seen    = 0;
      valid_wait    = 0;
      repeat (4) @(posedge clk);
      i_rst_n <= 1'b1;
      @(negedge clk);
      check_value("o_dump after reset", o_dump, 0);
      check_value("o_i2q2_valid after reset", o_i2q2_valid, 0);
      check_value("o_acc_i_prompt after reset", o_acc_i_prompt, 0);
      check_value("o_acc_q_prompt after reset", o_acc_q_prompt, 0);
      check_value("o_i2q2_early after reset", o_i2q2_early, 0);
      check_value("o_i2q2_prompt after reset", o_i2q2_prompt, 0);
      check_value("o_i2q2_late after reset", o_i2q2_late, 0);
      for (int r = 0; r < RUNS; r++) begin
         do_run();
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- gps_channel.f
logic/gps_pkg.sv
logic/channel_ctrl.sv
logic/ca_code_gen.sv
logic/carrier_nco.sv
logic/correlator.sv
logic/power_pipeline.sv
logic/gps_channel.sv
sim/gps_channel_assert.sv
sim/gps_channel_tb.sv
